/* logic/exe_alu.sv */
`timescale 1ns/1ps

module exe_alu (
	input  logic [exe_isa_pkg::XLEN-1:0] operand_a_i,
	input  logic [exe_isa_pkg::XLEN-1:0] operand_b_i,
	input  exe_ctrl_pkg::alu_op_e        alu_op_i,
	output logic [exe_isa_pkg::XLEN-1:0] result_o,
	output exe_ctrl_pkg::alu_status_t    status_o
);

	logic                        sub_sel;  // Adder in subtract mode
	logic [exe_isa_pkg::XLEN-1:0] b_op;     // Operand b, inverted for sub
	logic [exe_isa_pkg::XLEN:0]   sum_ext;  // Sum with carry out
	logic [exe_isa_pkg::XLEN-1:0] sum;
	logic                        overflow; // Signed overflow of a - b

	assign sub_sel = (alu_op_i == exe_ctrl_pkg::ALU_SUB);
	assign b_op    = sub_sel ? ~operand_b_i : operand_b_i;

	// One adder for add and sub, carry in completes the two's complement
	assign sum_ext = {1'b0, operand_a_i} + {1'b0, b_op}
		+ {{exe_isa_pkg::XLEN{1'b0}}, sub_sel};
	assign sum     = sum_ext[exe_isa_pkg::XLEN-1:0];

	// Operands of different sign and result sign differs from a
	assign overflow = (operand_a_i[exe_isa_pkg::XLEN-1] ^ operand_b_i[exe_isa_pkg::XLEN-1])
		& (sum[exe_isa_pkg::XLEN-1] ^ operand_a_i[exe_isa_pkg::XLEN-1]);

	always_comb begin
		case (alu_op_i)
			exe_ctrl_pkg::ALU_ADD,
			exe_ctrl_pkg::ALU_SUB:    result_o = sum;
			exe_ctrl_pkg::ALU_AND:    result_o = operand_a_i & operand_b_i;
			exe_ctrl_pkg::ALU_OR:     result_o = operand_a_i | operand_b_i;
			exe_ctrl_pkg::ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
			exe_ctrl_pkg::ALU_PASS_A: result_o = operand_a_i; // Feeds the fast shift path
			default:                  result_o = sum;
		endcase
	end

	// Flags are only meaningful while the adder subtracts
	assign status_o.zero     = (sum == '0);
	assign status_o.negative = sum[exe_isa_pkg::XLEN-1] ^ overflow;
	assign status_o.borrow   = ~sum_ext[exe_isa_pkg::XLEN]; // No carry out means a < b

endmodule

/* logic/exe_branch_unit.sv */
`timescale 1ns/1ps

module exe_branch_unit (
	input  exe_ctrl_pkg::exe_op_e              op_i,
	input  logic                               en_i,
	input  logic [exe_isa_pkg::XLEN-1:0]       pc_i,
	input  logic [exe_isa_pkg::XLEN-1:0]       base_i,
	input  logic [exe_isa_pkg::OFF12_W-1:0]    offset12_i,
	input  logic [exe_isa_pkg::OFF20_W-1:0]    offset20_i,
	input  exe_ctrl_pkg::alu_status_t          status_i,
	output logic                               taken_o,
	output logic [exe_isa_pkg::XLEN-1:0]       target_o
);

	logic [exe_isa_pkg::XLEN-1:0] br_off;   // Branch offset, halfword scaled
	logic [exe_isa_pkg::XLEN-1:0] jal_off;  // Jal offset, halfword scaled
	logic [exe_isa_pkg::XLEN-1:0] jalr_off; // Jalr offset, byte granular
	logic [exe_isa_pkg::XLEN-1:0] jalr_sum;
	logic                         cond;     // Condition before enable

	// Sign extension of the immediates
	assign br_off   = {{(exe_isa_pkg::XLEN-exe_isa_pkg::OFF12_W-1){offset12_i[exe_isa_pkg::OFF12_W-1]}},
		offset12_i, 1'b0};
	assign jal_off  = {{(exe_isa_pkg::XLEN-exe_isa_pkg::OFF20_W-1){offset20_i[exe_isa_pkg::OFF20_W-1]}},
		offset20_i, 1'b0};
	assign jalr_off = {{(exe_isa_pkg::XLEN-exe_isa_pkg::OFF12_W){offset12_i[exe_isa_pkg::OFF12_W-1]}},
		offset12_i};
	assign jalr_sum = base_i + jalr_off;

	always_comb begin
		case (op_i)
			exe_ctrl_pkg::OP_BEQ:  cond = status_i.zero;
			exe_ctrl_pkg::OP_BNE:  cond = ~status_i.zero;
			exe_ctrl_pkg::OP_BLT:  cond = status_i.negative;
			exe_ctrl_pkg::OP_BGE:  cond = ~status_i.negative;
			exe_ctrl_pkg::OP_BLTU: cond = status_i.borrow;
			exe_ctrl_pkg::OP_BGEU: cond = ~status_i.borrow;
			exe_ctrl_pkg::OP_JAL,
			exe_ctrl_pkg::OP_JALR: cond = 1'b1; // Unconditional
			default:               cond = 1'b0;
		endcase
	end

	assign taken_o = en_i & cond;

	always_comb begin
		case (op_i)
			exe_ctrl_pkg::OP_JAL:  target_o = pc_i + jal_off;
			exe_ctrl_pkg::OP_JALR: target_o = {jalr_sum[exe_isa_pkg::XLEN-1:1], 1'b0}; // Bit 0 cleared
			default:               target_o = pc_i + br_off;
		endcase
	end

endmodule

/* logic/exe_control_unit.sv */
`timescale 1ns/1ps

module exe_control_unit (
	input  logic                                  clk_i,
	input  logic                                  rstn_i,
	input  logic                                  new_instr_i,
	input  exe_ctrl_pkg::exe_op_e                 op_i,
	input  logic [exe_isa_pkg::SHAMT_W-1:0]       shamt_i,
	input  logic                                  shift_done_i,
	output exe_ctrl_pkg::alu_op_e                 alu_op_o,
	output exe_ctrl_pkg::shift_mode_e             shift_mode_o,
	output logic                                  shift_start_o,
	output exe_ctrl_pkg::result_sel_e             result_sel_o,
	output logic                                  branch_en_o,
	output logic                                  busy_o,
	output logic                                  complete_o
);

	logic                      is_shift;    // Any of sll/srl/sra
	logic                      multi_shift; // Needs the serial shifter
	logic                      busy_q;      // Serial shift in flight
	exe_ctrl_pkg::result_sel_e shift_sel;   // Result source for a shift

	assign is_shift = (op_i == exe_ctrl_pkg::OP_SLL) | (op_i == exe_ctrl_pkg::OP_SRL)
		| (op_i == exe_ctrl_pkg::OP_SRA);

	// Amounts 0 and 1 stay on the ALU path
	assign multi_shift = is_shift & (|shamt_i[exe_isa_pkg::SHAMT_W-1:1]);
	assign shift_sel   = multi_shift ? exe_ctrl_pkg::RES_SHIFTN :
		(shamt_i[0] ? exe_ctrl_pkg::RES_SHIFT1 : exe_ctrl_pkg::RES_ALU);

	always_comb begin
		alu_op_o     = exe_ctrl_pkg::ALU_ADD;
		shift_mode_o = exe_ctrl_pkg::SHIFT_NONE;
		result_sel_o = exe_ctrl_pkg::RES_ALU;
		branch_en_o  = 1'b0;
		case (op_i)
			exe_ctrl_pkg::OP_ADD: alu_op_o = exe_ctrl_pkg::ALU_ADD;
			exe_ctrl_pkg::OP_SUB: alu_op_o = exe_ctrl_pkg::ALU_SUB;
			exe_ctrl_pkg::OP_AND: alu_op_o = exe_ctrl_pkg::ALU_AND;
			exe_ctrl_pkg::OP_OR:  alu_op_o = exe_ctrl_pkg::ALU_OR;
			exe_ctrl_pkg::OP_XOR: alu_op_o = exe_ctrl_pkg::ALU_XOR;
			exe_ctrl_pkg::OP_SLT, exe_ctrl_pkg::OP_SLTU: begin
				alu_op_o     = exe_ctrl_pkg::ALU_SUB; // Compare via status
				result_sel_o = exe_ctrl_pkg::RES_SLT;
			end
			exe_ctrl_pkg::OP_SLL, exe_ctrl_pkg::OP_SRL, exe_ctrl_pkg::OP_SRA: begin
				alu_op_o     = exe_ctrl_pkg::ALU_PASS_A; // Operand a for the fast path
				result_sel_o = shift_sel;
				if (op_i == exe_ctrl_pkg::OP_SLL) shift_mode_o = exe_ctrl_pkg::SHIFT_LEFT;
				else if (op_i == exe_ctrl_pkg::OP_SRL) shift_mode_o = exe_ctrl_pkg::SHIFT_RIGHT;
				else shift_mode_o = exe_ctrl_pkg::SHIFT_ARIGHT;
			end
			exe_ctrl_pkg::OP_AUIPC: result_sel_o = exe_ctrl_pkg::RES_AUIPC;
			exe_ctrl_pkg::OP_JAL, exe_ctrl_pkg::OP_JALR: begin
				result_sel_o = exe_ctrl_pkg::RES_LINK; // Return address
				branch_en_o  = 1'b1;
			end
			exe_ctrl_pkg::OP_BEQ, exe_ctrl_pkg::OP_BNE, exe_ctrl_pkg::OP_BLT,
			exe_ctrl_pkg::OP_BGE, exe_ctrl_pkg::OP_BLTU, exe_ctrl_pkg::OP_BGEU: begin
				alu_op_o    = exe_ctrl_pkg::ALU_SUB; // Condition from sub status
				branch_en_o = 1'b1;
			end
			default: alu_op_o = exe_ctrl_pkg::ALU_ADD;
		endcase
	end

	// Strobes are only accepted when idle
	assign shift_start_o = new_instr_i & ~busy_q & multi_shift;
	assign complete_o    = busy_q ? shift_done_i : (new_instr_i & ~multi_shift);
	assign busy_o        = busy_q;

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			busy_q <= 1'b0;
		end else if (shift_start_o) begin
			busy_q <= 1'b1; // Held until the shifter reports done
		end else if (shift_done_i) begin
			busy_q <= 1'b0;
		end
	end

	// Write-back is a single-cycle pulse
	a_complete_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
		complete_o |=> !complete_o);

	// No back-pressure, so a strobe while busy would be lost
	a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		new_instr_i |-> !busy_q);

	// A done outside a long shift never reaches write-back
	a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		shift_done_i |-> busy_q);

endmodule

/* logic/exe_ctrl_pkg.sv */
package exe_ctrl_pkg;

	// Decoded operation as delivered by the decode stage
	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLTU,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_BGE,
		OP_BLTU,
		OP_BGEU
	} exe_op_e;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_A
	} alu_op_e;

	// Shift direction, also used by the single-bit shift in the top level
	typedef enum logic [1:0] {
		SHIFT_NONE,
		SHIFT_LEFT,
		SHIFT_RIGHT,
		SHIFT_ARIGHT
	} shift_mode_e;

	// Write-back source select
	typedef enum logic [2:0] {
		RES_ALU,
		RES_SLT,
		RES_SHIFT1,
		RES_SHIFTN,
		RES_LINK,
		RES_AUIPC
	} result_sel_e;

	// Status of the last subtraction
	typedef struct packed {
		logic zero;     // a == b
		logic negative; // Signed a < b, overflow already folded in
		logic borrow;   // Unsigned a < b
	} alu_status_t;

	// One step of shifting, shared by the serial shifter and the fast path
	function automatic logic [exe_isa_pkg::XLEN-1:0] shift_one(
		input logic [exe_isa_pkg::XLEN-1:0] value,
		input shift_mode_e                  mode
	);
		case (mode)
			SHIFT_LEFT:   shift_one = {value[exe_isa_pkg::XLEN-2:0], 1'b0};
			SHIFT_RIGHT:  shift_one = {1'b0, value[exe_isa_pkg::XLEN-1:1]};
			SHIFT_ARIGHT: shift_one = {value[exe_isa_pkg::XLEN-1], value[exe_isa_pkg::XLEN-1:1]};
			default:      shift_one = value; // No shift requested
		endcase
	endfunction

endpackage

/* logic/exe_isa_pkg.sv */
package exe_isa_pkg;

	// Datapath width, data and addresses share it
	localparam int unsigned XLEN = 32;

	// Destination register index width, x0..x31
	localparam int unsigned REG_ADDR_W = 5;

	// Shift amount is the low bits of operand b
	localparam int unsigned SHAMT_W = 5;

	// Unit step for the shift down-counter
	localparam logic [SHAMT_W-1:0] SHAMT_ONE = 1;

	// Branch/jalr immediate width
	localparam int unsigned OFF12_W = 12;

	// Jal immediate width
	localparam int unsigned OFF20_W = 20;

	// Sequential fetch increment, also the link value offset
	localparam logic [XLEN-1:0] PC_STEP = 4;

endpackage

/* logic/exe_shift_unit.sv */
`timescale 1ns/1ps

module exe_shift_unit (
	input  logic                            clk_i,
	input  logic                            rstn_i,
	input  logic [exe_isa_pkg::XLEN-1:0]    operand_i,
	input  logic [exe_isa_pkg::SHAMT_W-1:0] shamt_i,
	input  exe_ctrl_pkg::shift_mode_e       mode_i,
	input  logic                            start_i,
	output logic                            done_o,
	output logic [exe_isa_pkg::XLEN-1:0]    result_o
);

	logic                            active_q; // Shift sequence running
	logic [exe_isa_pkg::SHAMT_W-1:0] count_q;  // Steps still to go
	logic [exe_isa_pkg::XLEN-1:0]    data_q;   // Partially shifted value
	exe_ctrl_pkg::shift_mode_e       mode_q;   // Direction latched at start

	// Control state
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			active_q <= 1'b0;
			count_q  <= '0;
		end else if (start_i) begin
			active_q <= 1'b1;
			count_q  <= shamt_i - exe_isa_pkg::SHAMT_ONE; // First step taken on load
		end else if (active_q) begin
			if (count_q == '0) begin
				active_q <= 1'b0; // Result consumed this edge
			end else begin
				count_q <= count_q - exe_isa_pkg::SHAMT_ONE;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			data_q <= exe_ctrl_pkg::shift_one(operand_i, mode_i);
			mode_q <= mode_i;
		end else if (active_q && (count_q != '0)) begin
			data_q <= exe_ctrl_pkg::shift_one(data_q, mode_q); // One bit per cycle
		end
	end

	// Last step already applied once the count hits zero
	assign done_o   = active_q & (count_q == '0);
	assign result_o = data_q;

	// A restart would corrupt the running shift
	a_no_restart: assert property (@(posedge clk_i) disable iff (!rstn_i)
		start_i |-> !active_q);

endmodule

/* logic/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage (
	input  logic                               clk_i,
	input  logic                               rstn_i,
	input  logic                               exe_new_instr_i,
	input  exe_ctrl_pkg::exe_op_e              exe_op_i,
	input  logic [exe_isa_pkg::XLEN-1:0]       exe_operand_a_i,
	input  logic [exe_isa_pkg::XLEN-1:0]       exe_operand_b_i,
	input  logic [exe_isa_pkg::REG_ADDR_W-1:0] exe_rd_addr_i,
	input  logic [exe_isa_pkg::XLEN-1:0]       exe_pc_i,
	input  logic [exe_isa_pkg::OFF12_W-1:0]    exe_offset12_i,
	input  logic [exe_isa_pkg::OFF20_W-1:0]    exe_offset20_i,
	output logic [exe_isa_pkg::XLEN-1:0]       exe_result_o,
	output logic [exe_isa_pkg::REG_ADDR_W-1:0] exe_rd_addr_o,
	output logic [exe_isa_pkg::XLEN-1:0]       exe_next_pc_o,
	output logic                               exe_branch_taken_o,
	output logic                               exe_reg_wr_en_o,
	output logic                               exe_busy_o
);

	exe_ctrl_pkg::alu_op_e        alu_op;
	exe_ctrl_pkg::shift_mode_e    shift_mode;
	exe_ctrl_pkg::result_sel_e    result_sel;
	exe_ctrl_pkg::alu_status_t    alu_status;
	logic                         shift_start;
	logic                         shift_done;
	logic                         branch_en;
	logic                         complete;    // Registers the outputs this edge
	logic                         taken;
	logic                         slt_bit;     // Signed or unsigned compare outcome
	logic [exe_isa_pkg::SHAMT_W-1:0] shamt;
	logic [exe_isa_pkg::XLEN-1:0] alu_result;
	logic [exe_isa_pkg::XLEN-1:0] shift_result;
	logic [exe_isa_pkg::XLEN-1:0] target;
	logic [exe_isa_pkg::XLEN-1:0] pc_plus4;    // Sequential PC and link value
	logic [exe_isa_pkg::XLEN-1:0] result_mux;
	logic [exe_isa_pkg::XLEN-1:0] next_pc_mux;

	assign shamt    = exe_operand_b_i[exe_isa_pkg::SHAMT_W-1:0];
	assign pc_plus4 = exe_pc_i + exe_isa_pkg::PC_STEP;

	exe_control_unit u_ctrl (
		.clk_i         (clk_i),
		.rstn_i        (rstn_i),
		.new_instr_i   (exe_new_instr_i),
		.op_i          (exe_op_i),
		.shamt_i       (shamt),
		.shift_done_i  (shift_done),
		.alu_op_o      (alu_op),
		.shift_mode_o  (shift_mode),
		.shift_start_o (shift_start),
		.result_sel_o  (result_sel),
		.branch_en_o   (branch_en),
		.busy_o        (exe_busy_o),
		.complete_o    (complete)
	);

	exe_alu u_alu (
		.operand_a_i (exe_operand_a_i),
		.operand_b_i (exe_operand_b_i),
		.alu_op_i    (alu_op),
		.result_o    (alu_result),
		.status_o    (alu_status)
	);

	exe_shift_unit u_shift (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.operand_i (exe_operand_a_i),
		.shamt_i   (shamt),
		.mode_i    (shift_mode),
		.start_i   (shift_start),
		.done_o    (shift_done),
		.result_o  (shift_result)
	);

	exe_branch_unit u_branch (
		.op_i       (exe_op_i),
		.en_i       (branch_en),
		.pc_i       (exe_pc_i),
		.base_i     (exe_operand_a_i),
		.offset12_i (exe_offset12_i),
		.offset20_i (exe_offset20_i),
		.status_i   (alu_status),
		.taken_o    (taken),
		.target_o   (target)
	);

	// Sltu reads the borrow, slt the signed flag
	assign slt_bit = (exe_op_i == exe_ctrl_pkg::OP_SLTU) ? alu_status.borrow : alu_status.negative;

	always_comb begin
		case (result_sel)
			exe_ctrl_pkg::RES_SLT:    result_mux = {{(exe_isa_pkg::XLEN-1){1'b0}}, slt_bit};
			exe_ctrl_pkg::RES_SHIFT1: result_mux = exe_ctrl_pkg::shift_one(alu_result, shift_mode);
			exe_ctrl_pkg::RES_SHIFTN: result_mux = shift_result;
			exe_ctrl_pkg::RES_LINK:   result_mux = pc_plus4;
			exe_ctrl_pkg::RES_AUIPC:  result_mux = exe_pc_i + exe_operand_b_i;
			default:                  result_mux = alu_result; // Plain ALU and zero shifts
		endcase
	end

	assign next_pc_mux = taken ? target : pc_plus4;

	// Outputs hold their value between completions
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			exe_reg_wr_en_o    <= 1'b0;
			exe_result_o       <= '0;
			exe_rd_addr_o      <= '0;
			exe_next_pc_o      <= '0;
			exe_branch_taken_o <= 1'b0;
		end else begin
			exe_reg_wr_en_o <= complete; // One cycle per instruction
			if (complete) begin
				exe_result_o       <= result_mux;
				exe_rd_addr_o      <= exe_rd_addr_i;
				exe_next_pc_o      <= next_pc_mux;
				exe_branch_taken_o <= taken;
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the execution stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module exe_stage_tb -o exe_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/exe_stage_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q -F "*** TEST PASSED ***"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1

/* sim/exe_ref_model.svh */
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

// Expected write-back value, straight from the RV32I definitions
function automatic logic [exe_isa_pkg::XLEN-1:0] expected_result(
	input exe_ctrl_pkg::exe_op_e        op,
	input logic [exe_isa_pkg::XLEN-1:0] a,
	input logic [exe_isa_pkg::XLEN-1:0] b,
	input logic [exe_isa_pkg::XLEN-1:0] pc
);
	logic [exe_isa_pkg::SHAMT_W-1:0] sh;
	sh = b[exe_isa_pkg::SHAMT_W-1:0]; // Only the low bits count
	case (op)
		exe_ctrl_pkg::OP_ADD:   expected_result = a + b;
		exe_ctrl_pkg::OP_SUB:   expected_result = a - b;
		exe_ctrl_pkg::OP_AND:   expected_result = a & b;
		exe_ctrl_pkg::OP_OR:    expected_result = a | b;
		exe_ctrl_pkg::OP_XOR:   expected_result = a ^ b;
		exe_ctrl_pkg::OP_SLT:   expected_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		exe_ctrl_pkg::OP_SLTU:  expected_result = (a < b) ? 32'd1 : 32'd0;
		exe_ctrl_pkg::OP_SLL:   expected_result = a << sh;
		exe_ctrl_pkg::OP_SRL:   expected_result = a >> sh;
		exe_ctrl_pkg::OP_SRA:   expected_result = $signed(a) >>> sh; // Sign fill
		exe_ctrl_pkg::OP_AUIPC: expected_result = pc + b;
		exe_ctrl_pkg::OP_JAL,
		exe_ctrl_pkg::OP_JALR:  expected_result = pc + 32'd4; // Link
		default:                expected_result = a - b; // Branches, not checked
	endcase
endfunction

// Taken flag: any jump, or a branch whose condition holds
function automatic logic branch_outcome(
	input exe_ctrl_pkg::exe_op_e        op,
	input logic [exe_isa_pkg::XLEN-1:0] a,
	input logic [exe_isa_pkg::XLEN-1:0] b
);
	case (op)
		exe_ctrl_pkg::OP_BEQ:  branch_outcome = (a == b);
		exe_ctrl_pkg::OP_BNE:  branch_outcome = (a != b);
		exe_ctrl_pkg::OP_BLT:  branch_outcome = ($signed(a) < $signed(b));
		exe_ctrl_pkg::OP_BGE:  branch_outcome = ($signed(a) >= $signed(b));
		exe_ctrl_pkg::OP_BLTU: branch_outcome = (a < b);
		exe_ctrl_pkg::OP_BGEU: branch_outcome = (a >= b);
		exe_ctrl_pkg::OP_JAL,
		exe_ctrl_pkg::OP_JALR: branch_outcome = 1'b1;
		default:               branch_outcome = 1'b0;
	endcase
endfunction

// Next fetch address
function automatic logic [exe_isa_pkg::XLEN-1:0] target_pc(
	input exe_ctrl_pkg::exe_op_e          op,
	input logic [exe_isa_pkg::XLEN-1:0]   a,
	input logic [exe_isa_pkg::XLEN-1:0]   b,
	input logic [exe_isa_pkg::XLEN-1:0]   pc,
	input logic [exe_isa_pkg::OFF12_W-1:0] off12,
	input logic [exe_isa_pkg::OFF20_W-1:0] off20
);
	logic [exe_isa_pkg::XLEN-1:0] imm12; // Sign extended, not yet scaled
	logic [exe_isa_pkg::XLEN-1:0] imm20;
	logic [exe_isa_pkg::XLEN-1:0] sum;
	imm12 = {{(exe_isa_pkg::XLEN-exe_isa_pkg::OFF12_W){off12[exe_isa_pkg::OFF12_W-1]}}, off12};
	imm20 = {{(exe_isa_pkg::XLEN-exe_isa_pkg::OFF20_W){off20[exe_isa_pkg::OFF20_W-1]}}, off20};
	sum   = a + imm12;
	if (op == exe_ctrl_pkg::OP_JAL) target_pc = pc + (imm20 << 1);
	else if (op == exe_ctrl_pkg::OP_JALR) target_pc = sum & ~32'd1; // Bit 0 dropped
	else if (branch_outcome(op, a, b)) target_pc = pc + (imm12 << 1);
	else target_pc = pc + 32'd4;
endfunction

// Shift that needs the serial unit
function automatic logic is_long_shift(
	input exe_ctrl_pkg::exe_op_e        op,
	input logic [exe_isa_pkg::XLEN-1:0] b
);
	is_long_shift = (op == exe_ctrl_pkg::OP_SLL || op == exe_ctrl_pkg::OP_SRL
		|| op == exe_ctrl_pkg::OP_SRA) && (b[exe_isa_pkg::SHAMT_W-1:0] >= 5'd2);
endfunction

// Conditional branches leave a meaningless result
function automatic logic is_cond_branch(input exe_ctrl_pkg::exe_op_e op);
	is_cond_branch = (op == exe_ctrl_pkg::OP_BEQ || op == exe_ctrl_pkg::OP_BNE
		|| op == exe_ctrl_pkg::OP_BLT || op == exe_ctrl_pkg::OP_BGE
		|| op == exe_ctrl_pkg::OP_BLTU || op == exe_ctrl_pkg::OP_BGEU);
endfunction

`endif

/* sim/exe_stage_tb.sv */
`timescale 1ns/1ps

module exe_stage_tb;

	localparam int unsigned SEED          = 32'hb4e1_e607;
	localparam int          ALU_ROUNDS    = 8;
	localparam int          SHIFT_ROUNDS  = 8;  // First four use fixed amounts
	localparam int          BRANCH_KINDS  = 4;  // Operand pair classes
	localparam int          JUMP_ROUNDS   = 6;
	localparam int          NUM_INSTR     = 8 * ALU_ROUNDS + 3 * SHIFT_ROUNDS
		+ 6 * BRANCH_KINDS + 2 * JUMP_ROUNDS;
	localparam int          WB_TIMEOUT    = 40; // Driver gives up after this
	localparam int          LATENCY_LIMIT = 33; // Longest shift completes well inside

	logic                               clk_i;
	logic                               rstn_i;
	logic                               exe_new_instr_i;
	exe_ctrl_pkg::exe_op_e              exe_op_i;
	logic [exe_isa_pkg::XLEN-1:0]       exe_operand_a_i;
	logic [exe_isa_pkg::XLEN-1:0]       exe_operand_b_i;
	logic [exe_isa_pkg::REG_ADDR_W-1:0] exe_rd_addr_i;
	logic [exe_isa_pkg::XLEN-1:0]       exe_pc_i;
	logic [exe_isa_pkg::OFF12_W-1:0]    exe_offset12_i;
	logic [exe_isa_pkg::OFF20_W-1:0]    exe_offset20_i;
	logic [exe_isa_pkg::XLEN-1:0]       exe_result_o;
	logic [exe_isa_pkg::REG_ADDR_W-1:0] exe_rd_addr_o;
	logic [exe_isa_pkg::XLEN-1:0]       exe_next_pc_o;
	logic                               exe_branch_taken_o;
	logic                               exe_reg_wr_en_o;
	logic                               exe_busy_o;

	logic [exe_isa_pkg::XLEN-1:0]       exp_result = '0;  // Latched at the strobe
	logic [exe_isa_pkg::XLEN-1:0]       exp_next_pc = '0;
	logic [exe_isa_pkg::REG_ADDR_W-1:0] exp_rd = '0;
	logic                               exp_taken = 1'b0;
	logic                               exp_long = 1'b0;  // Serial shift expected
	logic                               exp_check_result = 1'b0;
	logic                               pending = 1'b0;   // Instruction in flight
	int                                 wait_cnt = 0;     // Cycles since the strobe
	int                                 issued = 0;
	int                                 value_errs = 0;
	int                                 protocol_errs = 0;

	exe_ctrl_pkg::exe_op_e alu_ops [8] = '{exe_ctrl_pkg::OP_ADD, exe_ctrl_pkg::OP_SUB,
		exe_ctrl_pkg::OP_AND, exe_ctrl_pkg::OP_OR, exe_ctrl_pkg::OP_XOR,
		exe_ctrl_pkg::OP_SLT, exe_ctrl_pkg::OP_SLTU, exe_ctrl_pkg::OP_AUIPC};
	exe_ctrl_pkg::exe_op_e shift_ops [3] = '{exe_ctrl_pkg::OP_SLL, exe_ctrl_pkg::OP_SRL,
		exe_ctrl_pkg::OP_SRA};
	exe_ctrl_pkg::exe_op_e branch_ops [6] = '{exe_ctrl_pkg::OP_BEQ, exe_ctrl_pkg::OP_BNE,
		exe_ctrl_pkg::OP_BLT, exe_ctrl_pkg::OP_BGE, exe_ctrl_pkg::OP_BLTU,
		exe_ctrl_pkg::OP_BGEU};
	exe_ctrl_pkg::exe_op_e jump_ops [2] = '{exe_ctrl_pkg::OP_JAL, exe_ctrl_pkg::OP_JALR};
	logic [exe_isa_pkg::SHAMT_W-1:0] shift_amts [4] = '{5'd0, 5'd1, 5'd2, 5'd31};

	`include "exe_ref_model.svh"

	exe_stage i_dut (
		.clk_i              (clk_i),
		.rstn_i             (rstn_i),
		.exe_new_instr_i    (exe_new_instr_i),
		.exe_op_i           (exe_op_i),
		.exe_operand_a_i    (exe_operand_a_i),
		.exe_operand_b_i    (exe_operand_b_i),
		.exe_rd_addr_i      (exe_rd_addr_i),
		.exe_pc_i           (exe_pc_i),
		.exe_offset12_i     (exe_offset12_i),
		.exe_offset20_i     (exe_offset20_i),
		.exe_result_o       (exe_result_o),
		.exe_rd_addr_o      (exe_rd_addr_o),
		.exe_next_pc_o      (exe_next_pc_o),
		.exe_branch_taken_o (exe_branch_taken_o),
		.exe_reg_wr_en_o    (exe_reg_wr_en_o),
		.exe_busy_o         (exe_busy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i; // 100 ns period
	end

	task automatic flag_mismatch(input string msg);
		value_errs++;
		$display("FAIL @ %0t ns: %s", $time, msg);
	endtask

	task automatic flag_protocol(input string msg);
		protocol_errs++;
		$display("Protocol error at %0t ns: %s", $time, msg);
	endtask

	// One instruction, strobe then wait for write-back
	task automatic drive_instr(
		input exe_ctrl_pkg::exe_op_e        op,
		input logic [exe_isa_pkg::XLEN-1:0] a,
		input logic [exe_isa_pkg::XLEN-1:0] b
	);
		logic [exe_isa_pkg::XLEN-1:0]       pc;
		logic [exe_isa_pkg::XLEN-1:0]       imm;
		logic [exe_isa_pkg::XLEN-1:0]       rd_word;
		logic [exe_isa_pkg::OFF12_W-1:0]    off12;
		logic [exe_isa_pkg::OFF20_W-1:0]    off20;
		int                                 waited;
		pc      = $urandom() & ~32'd3; // Word aligned
		imm     = $urandom();
		rd_word = $urandom();
		off12   = imm[exe_isa_pkg::OFF12_W-1:0];
		off20   = imm[exe_isa_pkg::XLEN-1:exe_isa_pkg::OFF12_W];
		waited  = 0;
		@(posedge clk_i);
		exe_new_instr_i  <= 1'b1;
		exe_op_i         <= op;
		exe_operand_a_i  <= a;
		exe_operand_b_i  <= b;
		exe_pc_i         <= pc;
		exe_offset12_i   <= off12;
		exe_offset20_i   <= off20;
		exe_rd_addr_i    <= rd_word[exe_isa_pkg::REG_ADDR_W-1:0];
		exp_result       <= expected_result(op, a, b, pc);
		exp_next_pc      <= target_pc(op, a, b, pc, off12, off20);
		exp_taken        <= branch_outcome(op, a, b);
		exp_rd           <= rd_word[exe_isa_pkg::REG_ADDR_W-1:0];
		exp_long         <= is_long_shift(op, b);
		exp_check_result <= !is_cond_branch(op);
		pending          <= 1'b1;
		issued           <= issued + 1;
		@(posedge clk_i);
		exe_new_instr_i <= 1'b0; // Operands stay held
		while (!exe_reg_wr_en_o && waited < WB_TIMEOUT) begin
			@(posedge clk_i);
			waited++;
		end
		if (!exe_reg_wr_en_o) flag_protocol("no write-back pulse after the strobe");
		pending <= 1'b0;
	endtask

	always @(posedge clk_i) begin
		if (!pending) wait_cnt <= 0;
		else wait_cnt <= wait_cnt + 1;
	end

	a_reset_state: assert property (@(posedge clk_i)
		$rose(rstn_i) |-> !exe_reg_wr_en_o && !exe_busy_o && !exe_branch_taken_o
			&& exe_next_pc_o == '0 && exe_result_o == '0 && exe_rd_addr_o == '0)
		else flag_mismatch("outputs not cleared by reset");

	a_result: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o && exp_check_result |-> exe_result_o == exp_result)
		else flag_mismatch($sformatf("%s result %h, expected %h", exe_op_i.name(),
			$sampled(exe_result_o), exp_result));

	a_rd_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o |-> exe_rd_addr_o == exp_rd)
		else flag_mismatch($sformatf("rd %0d, expected %0d", $sampled(exe_rd_addr_o), exp_rd));

	a_next_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o |-> exe_next_pc_o == exp_next_pc)
		else flag_mismatch($sformatf("%s next pc %h, expected %h", exe_op_i.name(),
			$sampled(exe_next_pc_o), exp_next_pc));

	a_taken: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o |-> exe_branch_taken_o == exp_taken)
		else flag_mismatch($sformatf("%s taken %b, expected %b", exe_op_i.name(),
			$sampled(exe_branch_taken_o), exp_taken));

	// Pulse shape and ownership
	a_single_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o |=> !exe_reg_wr_en_o)
		else flag_protocol("write enable stayed high for two cycles");

	a_no_spurious: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_reg_wr_en_o |-> pending)
		else flag_protocol("write enable pulsed with no instruction issued");

	a_short_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_new_instr_i && !exp_long |=> exe_reg_wr_en_o && !exe_busy_o)
		else flag_protocol("single-cycle operation did not write back on the next cycle");

	a_long_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		exe_new_instr_i && exp_long |=> exe_busy_o && !exe_reg_wr_en_o)
		else flag_protocol("long shift did not raise busy");

	a_latency_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
		pending |-> wait_cnt <= LATENCY_LIMIT)
		else flag_protocol("write-back took longer than the longest shift");

	initial begin
		int                           i;
		int                           k;
		logic [exe_isa_pkg::XLEN-1:0] r_a;
		logic [exe_isa_pkg::XLEN-1:0] r_b;
		void'($urandom(SEED));
		rstn_i          = 1'b0;
		exe_new_instr_i = 1'b0;
		exe_op_i        = exe_ctrl_pkg::OP_ADD;
		exe_operand_a_i = '0;
		exe_operand_b_i = '0;
		exe_rd_addr_i   = '0;
		exe_pc_i        = '0;
		exe_offset12_i  = '0;
		exe_offset20_i  = '0;
		repeat (4) @(posedge clk_i);
		rstn_i <= 1'b1;
		for (k = 0; k < 8; k++) begin
			for (i = 0; i < ALU_ROUNDS; i++) begin
				r_a = $urandom();
				r_b = (i == 0) ? r_a : $urandom(); // First round equal operands
				drive_instr(alu_ops[k], r_a, r_b);
			end
		end
		for (k = 0; k < 3; k++) begin
			for (i = 0; i < SHIFT_ROUNDS; i++) begin
				r_a = $urandom();
				r_b = $urandom(); // Upper bits must be ignored
				if (i < 4) r_b[exe_isa_pkg::SHAMT_W-1:0] = shift_amts[i];
				drive_instr(shift_ops[k], r_a, r_b);
			end
		end
		for (k = 0; k < 6; k++) begin
			for (i = 0; i < BRANCH_KINDS; i++) begin
				r_a = $urandom();
				r_b = $urandom();
				case (i)
					0: r_b = r_a;
					1: begin
						r_a[exe_isa_pkg::XLEN-1] = 1'b1; // Signed less, unsigned greater
						r_b[exe_isa_pkg::XLEN-1] = 1'b0;
					end
					2: begin
						r_a = r_a & 32'h3fff_ffff; // Less either way
						r_b = r_a + 32'd1 + {16'h0, r_b[15:0]};
					end
					default: begin
						r_a[exe_isa_pkg::XLEN-1] = 1'b0; // Signed greater, unsigned less
						r_b[exe_isa_pkg::XLEN-1] = 1'b1;
					end
				endcase
				drive_instr(branch_ops[k], r_a, r_b);
			end
		end
		for (k = 0; k < 2; k++) begin
			for (i = 0; i < JUMP_ROUNDS; i++) begin
				r_a = $urandom();
				r_b = $urandom();
				drive_instr(jump_ops[k], r_a, r_b);
			end
		end
		repeat (3) @(posedge clk_i); // Let the last checks fire
		$display("Issued %0d of %0d instructions, %0d value errors, %0d protocol errors",
			issued, NUM_INSTR, value_errs, protocol_errs);
		if (value_errs == 0 && protocol_errs == 0 && issued == NUM_INSTR) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (NUM_INSTR * 40 + 20) @(posedge clk_i);
		$display("Timeout: stimulus still running after %0d clock periods", NUM_INSTR * 40 + 20);
		$display("Issued %0d of %0d instructions, %0d value errors, %0d protocol errors",
			issued, NUM_INSTR, value_errs, protocol_errs);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+sim
logic/exe_isa_pkg.sv
logic/exe_ctrl_pkg.sv
logic/exe_alu.sv
logic/exe_shift_unit.sv
logic/exe_branch_unit.sv
logic/exe_control_unit.sv
logic/exe_stage.sv
sim/exe_stage_tb.sv
